/* common/ecc_defs.svh */
`ifndef ECC_DEFS_SVH
`define ECC_DEFS_SVH

// operand width of the prime field
`define ECC_W 32

// group order q = 2^32 - 5
// one conditional subtraction brings any 32-bit word below q
`define ECC_Q 32'hFFFF_FFFB

// operand memory address width in the arithmetic unit
`define ECC_MEM_AW 4

// microcode program counter
`define ECC_PC_W 5

// program entry points, address 0 holds the abort END word
`define ECC_SIGN_PC 5'd1
`define ECC_VER_PC 5'd14

// mask LFSR start value, must be nonzero
`define ECC_LFSR_SEED 32'hACE1_2468

`endif

/* common/ecc_pkg.sv */
`include "ecc_defs.svh"

package ecc_pkg;

    typedef enum logic [1:0] {
        CMD_NONE   = 2'd0,
        CMD_SIGN   = 2'd1,
        CMD_VERIFY = 2'd2
    } ecc_cmd_e;

    // END is zero so an unprogrammed ROM word stops the program
    typedef enum logic [2:0] {
        UOP_END   = 3'd0,
        UOP_LOAD  = 3'd1,
        UOP_ADD   = 3'd2,
        UOP_SUB   = 3'd3,
        UOP_MUL   = 3'd4,
        UOP_STORE = 3'd5
    } uop_e;

    typedef enum logic [3:0] {
        REG_PRIVKEY = 4'd0,
        REG_MSG     = 4'd1,
        REG_R       = 4'd2,
        REG_S       = 4'd3,
        REG_MASK    = 4'd4
    } reg_id_e;

    //------------------------------------------------------------------
    // microcode word, decoded as a move or as an arithmetic op
    //------------------------------------------------------------------
    typedef struct packed {
        uop_e                   op;
        logic [4:0]             rsvd;
        reg_id_e                reg_id;
        logic [`ECC_MEM_AW-1:0] addr;
    } ucode_mov_t;

    typedef struct packed {
        uop_e                   op;
        logic                   rsvd;
        logic [`ECC_MEM_AW-1:0] dst;
        logic [`ECC_MEM_AW-1:0] src_a;
        logic [`ECC_MEM_AW-1:0] src_b;
    } ucode_alu_t;

    typedef union packed {
        ucode_mov_t mov;
        ucode_alu_t alu;
    } ucode_u;

    // host command with its operands
    typedef struct packed {
        ecc_cmd_e          cmd;
        logic [`ECC_W-1:0] privkey;
        logic [`ECC_W-1:0] msg;
        logic [`ECC_W-1:0] r;
        logic [`ECC_W-1:0] s;
    } cmd_req_t;

    typedef struct packed {
        ucode_u instr;
        logic   start;
    } alu_req_t;

    typedef struct packed {
        logic [`ECC_W-1:0] value;
        logic              err;
        logic              match;
    } res_t;

endpackage

/* sequencer/ecc_ucode_rom.sv */
`timescale 1ns/1ps
`include "ecc_defs.svh"

module ecc_ucode_rom (
    input  logic [`ECC_PC_W-1:0] pc_i,
    output ecc_pkg::ucode_u      instr_o
);
    import ecc_pkg::*;

    localparam logic [`ECC_PC_W-1:0] BODY_LEN = 5'd11;

    function automatic ucode_u mov(input uop_e op, input reg_id_e id,
                                   input logic [`ECC_MEM_AW-1:0] addr);
        ucode_u w;
        w.mov = '{op: op, rsvd: '0, reg_id: id, addr: addr};
        return w;
    endfunction

    function automatic ucode_u alu(input uop_e op, input logic [`ECC_MEM_AW-1:0] dst,
                                   input logic [`ECC_MEM_AW-1:0] a,
                                   input logic [`ECC_MEM_AW-1:0] b);
        ucode_u w;
        w.alu = '{op: op, rsvd: 1'b0, dst: dst, src_a: a, src_b: b};
        return w;
    endfunction

    // masked signature body shared by both programs
    // m0 priv, m1 r, m2 msg, m3 d, result lands in m10
    function automatic ucode_u body(input logic [3:0] k);
        case (k)
            4'd0:    return mov(UOP_LOAD, REG_PRIVKEY, 4'd0);
            4'd1:    return mov(UOP_LOAD, REG_R, 4'd1);
            4'd2:    return mov(UOP_LOAD, REG_MSG, 4'd2);
            4'd3:    return mov(UOP_LOAD, REG_MASK, 4'd3);
            4'd4:    return alu(UOP_SUB, 4'd4, 4'd0, 4'd3);
            4'd5:    return alu(UOP_MUL, 4'd5, 4'd4, 4'd1);
            4'd6:    return alu(UOP_SUB, 4'd6, 4'd2, 4'd3);
            4'd7:    return alu(UOP_ADD, 4'd7, 4'd5, 4'd6);
            4'd8:    return alu(UOP_MUL, 4'd8, 4'd3, 4'd1);
            4'd9:    return alu(UOP_ADD, 4'd9, 4'd8, 4'd3);
            default: return alu(UOP_ADD, 4'd10, 4'd7, 4'd9);
        endcase
    endfunction

    always_comb begin
        instr_o = mov(UOP_END, REG_PRIVKEY, '0);
        if (pc_i >= `ECC_SIGN_PC && pc_i < `ECC_SIGN_PC + BODY_LEN) begin
            instr_o = body(4'(pc_i - `ECC_SIGN_PC));
        end else if (pc_i == `ECC_SIGN_PC + BODY_LEN) begin
            instr_o = mov(UOP_STORE, REG_PRIVKEY, 4'd10);
        end else if (pc_i >= `ECC_VER_PC && pc_i < `ECC_VER_PC + BODY_LEN) begin
            instr_o = body(4'(pc_i - `ECC_VER_PC));
        end else if (pc_i == `ECC_VER_PC + BODY_LEN) begin
            instr_o = mov(UOP_LOAD, REG_S, 4'd11);
        end else if (pc_i == `ECC_VER_PC + BODY_LEN + 5'd1) begin
            // zero difference means the given s matches
            instr_o = alu(UOP_SUB, 4'd12, 4'd10, 4'd11);
        end else if (pc_i == `ECC_VER_PC + BODY_LEN + 5'd2) begin
            instr_o = mov(UOP_STORE, REG_PRIVKEY, 4'd12);
        end
    end

endmodule

/* sequencer/ecc_dsa_fsm.sv */
`timescale 1ns/1ps
`include "ecc_defs.svh"

module ecc_dsa_fsm (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 start_i,
    input  ecc_pkg::ecc_cmd_e    cmd_i,
    input  logic                 range_err_i,
    output logic [`ECC_PC_W-1:0] pc_o,
    input  ecc_pkg::ucode_u      instr_i,
    output ecc_pkg::alu_req_t    alu_req_o,
    input  logic                 alu_busy_i,
    output ecc_pkg::reg_id_e     load_sel_o,
    output logic                 store_o,
    output logic                 done_o
);
    import ecc_pkg::*;

    // address 0 holds END, used to abort a command
    localparam logic [`ECC_PC_W-1:0] ABORT_PC = '0;

    logic                 run_q;
    logic [`ECC_PC_W-1:0] pc_q;
    logic [`ECC_PC_W-1:0] entry_pc;
    logic                 step;
    uop_e                 op;

    //------------------------------------------------------------------
    // command dispatch
    //------------------------------------------------------------------
    always_comb begin
        case (cmd_i)
            CMD_SIGN:   entry_pc = `ECC_SIGN_PC;
            CMD_VERIFY: entry_pc = `ECC_VER_PC;
            default:    entry_pc = ABORT_PC;
        endcase
        if (range_err_i) begin
            entry_pc = ABORT_PC;
        end
    end

    // pc holds while the ALU is busy
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            run_q <= 1'b0;
            pc_q  <= ABORT_PC;
        end else if (!run_q) begin
            if (start_i) begin
                run_q <= 1'b1;
                pc_q  <= entry_pc;
            end
        end else if (!alu_busy_i) begin
            if (op == UOP_END) begin
                run_q <= 1'b0;
            end else begin
                pc_q <= pc_q + 1'b1;
            end
        end
    end

    //------------------------------------------------------------------
    // instruction issue
    //------------------------------------------------------------------
    assign op   = instr_i.mov.op;
    assign step = run_q && !alu_busy_i;
    assign pc_o = pc_q;

    always_comb begin
        alu_req_o.instr = instr_i;
        alu_req_o.start = step && (op inside {UOP_LOAD, UOP_ADD, UOP_SUB, UOP_MUL});
    end

    assign load_sel_o = instr_i.mov.reg_id;
    assign store_o    = step && (op == UOP_STORE);
    // single cycle, the FSM drops to idle on the same edge
    assign done_o     = step && (op == UOP_END);

endmodule

/* arith/ecc_mod_alu.sv */
`timescale 1ns/1ps
`include "ecc_defs.svh"

module ecc_mod_alu (
    input  logic              clk,
    input  logic              reset_n,
    input  ecc_pkg::alu_req_t req_i,
    input  logic [`ECC_W-1:0] load_data_i,
    output logic [`ECC_W-1:0] rd_data_o,
    output logic              busy_o
);
    import ecc_pkg::*;

    localparam logic [`ECC_W-1:0] Q = `ECC_Q;
    localparam int DEPTH = 1 << `ECC_MEM_AW;
    localparam logic [4:0] LAST_BIT = 5'd31;

    logic [`ECC_W-1:0]      mem [DEPTH];
    logic [`ECC_W-1:0]      opa;
    logic [`ECC_W-1:0]      opb;
    logic [`ECC_W-1:0]      mul_a;
    logic [`ECC_W-1:0]      mul_b;
    logic [`ECC_W-1:0]      acc;
    logic [`ECC_W-1:0]      acc_dbl;
    logic [`ECC_W-1:0]      acc_next;
    logic [`ECC_MEM_AW-1:0] mul_dst;
    logic [4:0]             bit_cnt;
    logic                   mul_start;
    uop_e                   op;

    function automatic logic [`ECC_W-1:0] mod_add(input logic [`ECC_W-1:0] a,
                                                  input logic [`ECC_W-1:0] b);
        logic [`ECC_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= {1'b0, Q}) begin
            sum = sum - {1'b0, Q};
        end
        return sum[`ECC_W-1:0];
    endfunction

    // a wrapped difference plus q lands back in range
    function automatic logic [`ECC_W-1:0] mod_sub(input logic [`ECC_W-1:0] a,
                                                  input logic [`ECC_W-1:0] b);
        logic [`ECC_W-1:0] diff;
        diff = a - b;
        if (a < b) begin
            diff = diff + Q;
        end
        return diff;
    endfunction

    function automatic logic [`ECC_W-1:0] reduce(input logic [`ECC_W-1:0] x);
        return (x >= Q) ? x - Q : x;
    endfunction

    assign op        = req_i.instr.alu.op;
    assign opa       = mem[req_i.instr.alu.src_a];
    assign opb       = mem[req_i.instr.alu.src_b];
    assign rd_data_o = mem[req_i.instr.mov.addr];
    assign mul_start = req_i.start && (op == UOP_MUL);

    //------------------------------------------------------------------
    // serial multiply, MSB first double and add
    //------------------------------------------------------------------
    assign acc_dbl  = mod_add(acc, acc);
    assign acc_next = mul_b[`ECC_W-1] ? mod_add(acc_dbl, mul_a) : acc_dbl;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_o  <= 1'b0;
            bit_cnt <= '0;
        end else if (mul_start) begin
            busy_o  <= 1'b1;
            bit_cnt <= '0;
        end else if (busy_o) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == LAST_BIT) begin
                busy_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul_start) begin
            mul_a   <= opa;
            mul_b   <= opb;
            mul_dst <= req_i.instr.alu.dst;
            acc     <= '0;
        end else if (busy_o) begin
            acc   <= acc_next;
            mul_b <= mul_b << 1;
        end
    end

    // operand memory writes
    always_ff @(posedge clk) begin
        if (req_i.start) begin
            case (op)
                UOP_LOAD: mem[req_i.instr.mov.addr] <= reduce(load_data_i);
                UOP_ADD:  mem[req_i.instr.alu.dst] <= mod_add(opa, opb);
                UOP_SUB:  mem[req_i.instr.alu.dst] <= mod_sub(opa, opb);
                default:  ;
            endcase
        end else if (busy_o && bit_cnt == LAST_BIT) begin
            mem[mul_dst] <= acc_next;
        end
    end

endmodule

/* design/ecc_io_regs.sv */
`timescale 1ns/1ps
`include "ecc_defs.svh"

module ecc_io_regs (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              cmd_valid_i,
    input  ecc_pkg::cmd_req_t cmd_i,
    output logic              cmd_ready_o,
    output logic              res_valid_o,
    output ecc_pkg::res_t     res_o,
    input  logic              res_ready_i,
    output logic              start_o,
    output ecc_pkg::ecc_cmd_e cmd_o,
    output logic              range_err_o,
    input  ecc_pkg::reg_id_e  load_sel_i,
    output logic [`ECC_W-1:0] load_data_o,
    input  logic              store_i,
    input  logic [`ECC_W-1:0] store_data_i,
    input  logic              done_i
);
    import ecc_pkg::*;

    localparam logic [`ECC_W-1:0] Q = `ECC_Q;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [`ECC_W-1:0] LFSR_POLY = 32'h8020_0003;

    cmd_req_t          op_q;
    logic [`ECC_W-1:0] msg_red_q;
    logic [`ECC_W-1:0] mask_q;
    logic [`ECC_W-1:0] lfsr_q;
    logic              busy_q;
    logic              accept;

    function automatic logic out_of_range(input logic [`ECC_W-1:0] x);
        return (x == '0) || (x >= Q);
    endfunction

    // one command in flight until its result is taken
    assign cmd_ready_o = !busy_q;
    assign accept      = cmd_valid_i && cmd_ready_o;
    assign cmd_o       = op_q.cmd;

    // operands, reduced msg and the latched mask
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q      <= cmd_i;
            msg_red_q <= (cmd_i.msg >= Q) ? cmd_i.msg - Q : cmd_i.msg;
            mask_q    <= (lfsr_q >= Q) ? lfsr_q - Q : lfsr_q;
        end
    end

    always_comb begin
        case (op_q.cmd)
            CMD_SIGN:   range_err_o = out_of_range(op_q.privkey);
            CMD_VERIFY: range_err_o = out_of_range(op_q.r) || out_of_range(op_q.s);
            default:    range_err_o = 1'b0;
        endcase
    end

    always_comb begin
        case (load_sel_i)
            REG_PRIVKEY: load_data_o = op_q.privkey;
            REG_MSG:     load_data_o = msg_red_q;
            REG_R:       load_data_o = op_q.r;
            REG_S:       load_data_o = op_q.s;
            REG_MASK:    load_data_o = mask_q;
            default:     load_data_o = '0;
        endcase
    end

    //------------------------------------------------------------------
    // mask source, handshake and result register
    //------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lfsr_q      <= `ECC_LFSR_SEED;
            busy_q      <= 1'b0;
            start_o     <= 1'b0;
            res_valid_o <= 1'b0;
            res_o       <= '0;
        end else begin
            lfsr_q  <= {1'b0, lfsr_q[`ECC_W-1:1]} ^ (lfsr_q[0] ? LFSR_POLY : '0);
            start_o <= accept;
            if (accept) begin
                busy_q <= 1'b1;
                res_o  <= '0;
            end
            if (store_i) begin
                res_o.value <= store_data_i;
            end
            if (done_i) begin
                res_valid_o <= 1'b1;
                res_o.err   <= range_err_o;
                res_o.match <= (op_q.cmd == CMD_VERIFY) && !range_err_o
                               && (res_o.value == '0);
            end
            if (res_valid_o && res_ready_i) begin
                res_valid_o <= 1'b0;
                busy_q      <= 1'b0;
            end
        end
    end

endmodule

/* design/ecc_dsa_top.sv */
`timescale 1ns/1ps
`include "ecc_defs.svh"

module ecc_dsa_top (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              cmd_valid_i,
    input  ecc_pkg::cmd_req_t cmd_i,
    output logic              cmd_ready_o,
    output logic              res_valid_o,
    output ecc_pkg::res_t     res_o,
    input  logic              res_ready_i
);
    import ecc_pkg::*;

    logic                 start;
    ecc_cmd_e             cmd;
    logic                 range_err;
    reg_id_e              load_sel;
    logic [`ECC_W-1:0]    load_data;
    logic                 store;
    logic [`ECC_W-1:0]    rd_data;
    logic                 done;
    logic [`ECC_PC_W-1:0] pc;
    ucode_u               instr;
    alu_req_t             alu_req;
    logic                 alu_busy;

    ecc_io_regs ecc_io_regs_inst (
        .clk(clk),
        .reset_n(reset_n),
        .cmd_valid_i(cmd_valid_i),
        .cmd_i(cmd_i),
        .cmd_ready_o(cmd_ready_o),
        .res_valid_o(res_valid_o),
        .res_o(res_o),
        .res_ready_i(res_ready_i),
        .start_o(start),
        .cmd_o(cmd),
        .range_err_o(range_err),
        .load_sel_i(load_sel),
        .load_data_o(load_data),
        .store_i(store),
        .store_data_i(rd_data),
        .done_i(done)
    );

    ecc_dsa_fsm ecc_dsa_fsm_inst (
        .clk(clk),
        .reset_n(reset_n),
        .start_i(start),
        .cmd_i(cmd),
        .range_err_i(range_err),
        .pc_o(pc),
        .instr_i(instr),
        .alu_req_o(alu_req),
        .alu_busy_i(alu_busy),
        .load_sel_o(load_sel),
        .store_o(store),
        .done_o(done)
    );

    ecc_ucode_rom ecc_ucode_rom_inst (
        .pc_i(pc),
        .instr_o(instr)
    );

    ecc_mod_alu ecc_mod_alu_inst (
        .clk(clk),
        .reset_n(reset_n),
        .req_i(alu_req),
        .load_data_i(load_data),
        .rd_data_o(rd_data),
        .busy_o(alu_busy)
    );

endmodule

/* test/ecc_dsa_checker.sv */
`timescale 1ns/1ps
`include "ecc_defs.svh"

module ecc_dsa_checker (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            cmd_valid_i,
    input  logic            cmd_ready_i,
    input  logic            res_valid_i,
    input  ecc_pkg::res_t   res_i,
    input  logic            res_ready_i,
    input  ecc_pkg::res_t   exp_i,
    input  logic [8*16-1:0] name_i,
    output int              n_done_o,
    output int              n_pass_o,
    output int              n_fail_o
);
    import ecc_pkg::*;

    res_t            exp_q;
    res_t            held;
    logic [8*16-1:0] name_q;
    logic            holding;
    logic            reset_seen;
    logic            valid_q;
    int              cycle;
    int              accept_cycle;
    int              latency;

    // sample on the rising edge while the testbench drives on the falling one
    always @(posedge clk) begin
        if (!reset_n) begin
            n_done_o   = 0;
            n_pass_o   = 0;
            n_fail_o   = 0;
            holding    = 1'b0;
            reset_seen = 1'b0;
            valid_q    = 1'b0;
            cycle      = 0;
        end else begin
            cycle = cycle + 1;

            //----------------------------------------------------------
            // state right after reset
            //----------------------------------------------------------
            if (!reset_seen) begin
                reset_seen = 1'b1;
                n_done_o   = n_done_o + 1;
                if (res_valid_i !== 1'b0 || cmd_ready_i !== 1'b1) begin
                    $display("FAIL reset: expected valid 0 ready 1, actual valid %0b ready %0b",
                             res_valid_i, cmd_ready_i);
                    n_fail_o = n_fail_o + 1;
                end else begin
                    $display("PASS reset");
                    n_pass_o = n_pass_o + 1;
                end
            end

            // result must stay frozen while the host stalls
            if (holding) begin
                if (res_valid_i !== 1'b1 || res_i !== held || cmd_ready_i !== 1'b0) begin
                    $display("result changed or cmd_ready rose during back-pressure in %0s",
                             name_q);
                    n_fail_o = n_fail_o + 1;
                end
            end
            holding = res_valid_i && !res_ready_i;
            held    = res_i;

            // a rejected command skips the program and answers two cycles after acceptance
            // this edge sees the rise of res_valid one cycle late
            if (res_valid_i && !valid_q && exp_q.err) begin
                latency = cycle - accept_cycle - 1;
                if (latency != 2) begin
                    $display("range error result of %0s came %0d cycles after acceptance, not 2",
                             name_q, latency);
                    n_fail_o = n_fail_o + 1;
                end
            end
            valid_q = res_valid_i;

            if (cmd_valid_i && cmd_ready_i) begin
                exp_q        = exp_i;
                name_q       = name_i;
                accept_cycle = cycle;
            end

            //----------------------------------------------------------
            // result transfer
            //----------------------------------------------------------
            if (res_valid_i && res_ready_i) begin
                n_done_o = n_done_o + 1;
                if (res_i !== exp_q) begin
                    $display(
                        "FAIL %0s: expected %h err %0b match %0b, actual %h err %0b match %0b",
                        name_q, exp_q.value, exp_q.err, exp_q.match,
                        res_i.value, res_i.err, res_i.match);
                    n_fail_o = n_fail_o + 1;
                end else begin
                    $display("PASS %0s: value %h err %0b match %0b",
                             name_q, res_i.value, res_i.err, res_i.match);
                    n_pass_o = n_pass_o + 1;
                end
            end
        end
    end

endmodule

/* test/tb_ecc_dsa.sv */
`timescale 1ns/1ps
`include "ecc_defs.svh"

module tb_ecc_dsa;
    import ecc_pkg::*;

    localparam logic [`ECC_W-1:0] Q = `ECC_Q;
    localparam int WAIT_LIMIT = 300;

    logic              clk;
    logic              reset_n;
    logic              cmd_valid;
    cmd_req_t          cmd;
    logic              cmd_ready;
    logic              res_valid;
    res_t              res;
    logic              res_ready;
    res_t              exp_res;
    logic [8*16-1:0]   test_name;
    logic [`ECC_W-1:0] lcg_state;
    int                n_done;
    int                n_pass;
    int                n_fail;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    ecc_dsa_top ecc_dsa_top_inst (
        .clk(clk),
        .reset_n(reset_n),
        .cmd_valid_i(cmd_valid),
        .cmd_i(cmd),
        .cmd_ready_o(cmd_ready),
        .res_valid_o(res_valid),
        .res_o(res),
        .res_ready_i(res_ready)
    );

    ecc_dsa_checker ecc_dsa_checker_inst (
        .clk(clk),
        .reset_n(reset_n),
        .cmd_valid_i(cmd_valid),
        .cmd_ready_i(cmd_ready),
        .res_valid_i(res_valid),
        .res_i(res),
        .res_ready_i(res_ready),
        .exp_i(exp_res),
        .name_i(test_name),
        .n_done_o(n_done),
        .n_pass_o(n_pass),
        .n_fail_o(n_fail)
    );

    //------------------------------------------------------------------
    // stimulus helpers
    //------------------------------------------------------------------
    function automatic logic [`ECC_W-1:0] lcg_next(input logic [`ECC_W-1:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw(output logic [`ECC_W-1:0] v);
        lcg_state = lcg_next(lcg_state);
        v = lcg_state;
    endtask

    // maps any word onto 1 .. q-1
    function automatic logic [`ECC_W-1:0] in_range(input logic [`ECC_W-1:0] raw);
        return (raw % (Q - 1)) + 1;
    endfunction

    function automatic logic range_ok(input logic [`ECC_W-1:0] x);
        return (x != 0) && (x < Q);
    endfunction

    function automatic cmd_req_t make_cmd(input ecc_cmd_e op, input logic [`ECC_W-1:0] priv,
                                          input logic [`ECC_W-1:0] msg,
                                          input logic [`ECC_W-1:0] r,
                                          input logic [`ECC_W-1:0] s);
        cmd_req_t c;
        c.cmd     = op;
        c.privkey = priv;
        c.msg     = msg;
        c.r       = r;
        c.s       = s;
        return c;
    endfunction

    // s = privkey * r + msg mod q, verify gives that minus the given s
    function automatic res_t expected_result(input cmd_req_t c);
        logic [63:0] q64;
        logic [63:0] sig;
        logic [63:0] diff;
        res_t        e;
        q64 = {32'd0, Q};
        e   = '0;
        sig = (({32'd0, c.privkey} % q64) * ({32'd0, c.r} % q64)) % q64;
        sig = (sig + ({32'd0, c.msg} % q64)) % q64;
        if (c.cmd == CMD_SIGN) begin
            if (!range_ok(c.privkey)) begin
                e.err = 1'b1;
            end else begin
                e.value = sig[`ECC_W-1:0];
            end
        end else if (!range_ok(c.r) || !range_ok(c.s)) begin
            e.err = 1'b1;
        end else begin
            diff    = (sig + q64 - {32'd0, c.s}) % q64;
            e.value = diff[`ECC_W-1:0];
            e.match = (diff == 0);
        end
        return e;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $finish;
    endtask

    // one command through the DUT, hold keeps res_ready low that many cycles
    task automatic run_cmd(input logic [8*16-1:0] name, input cmd_req_t c, input int hold);
        int count;
        int done_before;
        done_before = n_done;
        count = 0;
        while (!cmd_ready) begin
            if (count == WAIT_LIMIT) begin
                abort_run("timeout: cmd_ready never went high");
            end
            @(negedge clk);
            count++;
        end
        exp_res   = expected_result(c);
        test_name = name;
        cmd       = c;
        cmd_valid = 1'b1;
        res_ready = (hold == 0);
        @(negedge clk);
        cmd_valid = 1'b0;
        count = 0;
        while (!res_valid) begin
            if (count == WAIT_LIMIT) begin
                abort_run("timeout: no result came back for the command");
            end
            @(negedge clk);
            count++;
        end
        repeat (hold) @(negedge clk);
        res_ready = 1'b1;
        count = 0;
        while (n_done == done_before) begin
            if (count == WAIT_LIMIT) begin
                abort_run("timeout: the result was never transferred");
            end
            @(negedge clk);
            count++;
        end
    endtask

    //------------------------------------------------------------------
    // test sequence
    //------------------------------------------------------------------
    initial begin
        cmd_req_t          c;
        res_t              sig;
        logic [`ECC_W-1:0] p;
        logic [`ECC_W-1:0] m;
        logic [`ECC_W-1:0] r;
        cmd_valid = 1'b0;
        cmd       = '0;
        res_ready = 1'b1;
        exp_res   = '0;
        test_name = "none";
        lcg_state = 32'd26;
        reset_n   = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        for (int i = 0; i < 6; i++) begin
            draw(p);
            draw(m);
            draw(r);
            run_cmd("sign_rand", make_cmd(CMD_SIGN, in_range(p), m, in_range(r), '0), 0);
        end

        // messages at or above q are reduced first
        draw(p);
        draw(r);
        run_cmd("sign_msg_q", make_cmd(CMD_SIGN, in_range(p), Q, in_range(r), '0), 0);
        run_cmd("sign_msg_max", make_cmd(CMD_SIGN, in_range(p), 32'hFFFF_FFFF,
                                         in_range(r), '0), 0);

        for (int i = 0; i < 3; i++) begin
            draw(p);
            draw(m);
            draw(r);
            c     = make_cmd(CMD_SIGN, in_range(p), m, in_range(r), '0);
            sig   = expected_result(c);
            c.cmd = CMD_VERIFY;
            c.s   = sig.value;
            run_cmd("verify_ok", c, 0);
            // always in range and never equal to the signature
            c.s = (sig.value % (Q - 1)) + 1;
            run_cmd("verify_bad", c, 0);
        end

        draw(m);
        draw(r);
        r = in_range(r);
        run_cmd("sign_priv_0", make_cmd(CMD_SIGN, '0, m, r, '0), 0);
        run_cmd("sign_priv_q", make_cmd(CMD_SIGN, Q, m, r, '0), 0);
        run_cmd("sign_priv_max", make_cmd(CMD_SIGN, 32'hFFFF_FFFF, m, r, '0), 0);
        run_cmd("verify_r_0", make_cmd(CMD_VERIFY, r, m, '0, r), 0);
        run_cmd("verify_r_q", make_cmd(CMD_VERIFY, r, m, Q, r), 0);
        run_cmd("verify_s_0", make_cmd(CMD_VERIFY, r, m, r, '0), 0);
        run_cmd("verify_s_max", make_cmd(CMD_VERIFY, r, m, r, 32'hFFFF_FFFF), 0);

        draw(p);
        draw(m);
        run_cmd("sign_backpress", make_cmd(CMD_SIGN, in_range(p), m, r, '0), 6);
        draw(p);
        draw(m);
        run_cmd("sign_after_hold", make_cmd(CMD_SIGN, in_range(p), m, r, '0), 0);

        repeat (2) @(negedge clk);
        $display("%0d results checked, %0d passed, %0d failed checks", n_done, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+common
common/ecc_pkg.sv
sequencer/ecc_ucode_rom.sv
sequencer/ecc_dsa_fsm.sv
arith/ecc_mod_alu.sv
design/ecc_io_regs.sv
design/ecc_dsa_top.sv
test/ecc_dsa_checker.sv
test/tb_ecc_dsa.sv

/* Bender.yml */
package:
  name: ecc_dsa

sources:
  - include_dirs:
      - common
    files:
      - common/ecc_pkg.sv
      - sequencer/ecc_ucode_rom.sv
      - sequencer/ecc_dsa_fsm.sv
      - arith/ecc_mod_alu.sv
      - design/ecc_io_regs.sv
      - design/ecc_dsa_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/ecc_dsa_checker.sv
      - test/tb_ecc_dsa.sv
